//--- include/eth_tx_defines.svh
`ifndef ETH_TX_DEFINES_SVH
`define ETH_TX_DEFINES_SVH

// Byte FIFO depth, also the starting byte credit count
`define ETH_TX_DATA_DEPTH 64

// Length FIFO depth in frames, also the starting frame credit count
`define ETH_TX_HDR_DEPTH 4

// Frame length width in bytes
`define ETH_TX_LEN_W 11

// APB address width
`define ETH_TX_ADDR_W 12

`endif

//--- rtl/eth_tx_reg_pkg.sv
`include "eth_tx_defines.svh"

package eth_tx_reg_pkg;

	// Address as seen on the APB completer side
	typedef logic [`ETH_TX_ADDR_W-1:0] apb_addr_t;

	// Register map
	// REG_TX_BUF and everything above it is the data window
	typedef enum apb_addr_t {
		REG_STAT   = 'h000,
		REG_COMMIT = 'h004,
		REG_TX_BUF = 'h010
	} reg_addr_t;

	// Index of a byte lane inside a 32-bit word
	typedef logic [1:0] lane_cnt_t;

	// Credit counters, wide enough to hold the full depth
	typedef logic [$clog2(`ETH_TX_DATA_DEPTH+1)-1:0] byte_credit_t;
	typedef logic [$clog2(`ETH_TX_HDR_DEPTH+1)-1:0]  frame_credit_t;

endpackage

//--- rtl/eth_tx_frame_pkg.sv
`include "eth_tx_defines.svh"

package eth_tx_frame_pkg;

	// Length of one committed frame in bytes
	typedef logic [`ETH_TX_LEN_W-1:0] frame_len_t;

	// Sender FSM
	// IDLE waits for a frame and tx_ready
	// POP latches the header
	// DATA walks through the payload bytes
	typedef enum logic [1:0] {
		SEND_IDLE = 2'd0,
		SEND_POP  = 2'd1,
		SEND_DATA = 2'd2
	} send_state_t;

endpackage

//--- rtl/eth_tx_ifs.sv
`timescale 1ns/1ps

//////////////////////////////
// Writer to store path, credit based

interface tx_push_if;
	import eth_tx_frame_pkg::*;

	// Byte push, one byte per cycle
	logic       push;
	logic [7:0] data;

	// Frame commit with its final length
	logic       commit;
	frame_len_t commit_len;

	// Single cycle credit returns from the store
	logic       byte_credit;
	logic       frame_credit;

	modport writer (
		output push, data, commit, commit_len,
		input  byte_credit, frame_credit
	);

	modport store (
		input  push, data, commit, commit_len,
		output byte_credit, frame_credit
	);
endinterface

//////////////////////////////
// Store to sender path

interface tx_pop_if;
	import eth_tx_frame_pkg::*;

	// Head of the length FIFO
	logic       frame_avail;
	frame_len_t frame_len;

	// Registered read data, valid the cycle after byte_pop
	logic [7:0] byte_data;

	logic       frame_pop;
	logic       byte_pop;

	modport store (
		output frame_avail, frame_len, byte_data,
		input  frame_pop, byte_pop
	);

	modport sender (
		input  frame_avail, frame_len, byte_data,
		output frame_pop, byte_pop
	);
endinterface

//--- rtl/apb_tx_regs.sv
`timescale 1ns/1ps
`include "eth_tx_defines.svh"

module apb_tx_regs (
	input  logic                      apb,
	input  logic                      rst,
	input  eth_tx_reg_pkg::apb_addr_t paddr,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic [31:0]               pwdata,
	input  logic [3:0]                pstrb,
	input  logic                      link_up,
	output logic [31:0]               prdata,
	output logic                      pready,
	output logic                      pslverr,
	tx_push_if.writer                 push
);
	import eth_tx_reg_pkg::*;
	import eth_tx_frame_pkg::*;

	logic          access;
	logic          is_stat;
	logic          is_commit;
	logic          is_buf;
	logic          buf_wr;
	logic          lane0_wr;
	logic          commit_wr;
	logic          push_next;
	lane_cnt_t     last_lane;
	lane_cnt_t     pend_cnt;
	logic [23:0]   pend_data;
	frame_len_t    frame_bytes;
	byte_credit_t  byte_cred;
	frame_credit_t frame_cred;

	//////////////////////////////
	// Address decode

	assign access    = psel && penable;
	assign is_stat   = (paddr == REG_STAT);
	assign is_commit = (paddr == REG_COMMIT);
	assign is_buf    = (paddr >= REG_TX_BUF);

	// Stall while bytes of the last word are still going out
	// A word needs room for four bytes, a real commit needs a header slot
	assign pready = access && (pend_cnt == '0)
		&& !(pwrite && is_buf && (byte_cred < 4))
		&& !(pwrite && is_commit && (frame_bytes != '0) && (frame_cred == '0));

	// Status is read only, everything else is write only
	assign pslverr = pready && (pwrite ? is_stat : !is_stat);
	assign prdata  = (pready && !pwrite && is_stat) ? {31'h0, link_up} : 32'h0;

	assign buf_wr    = pready && pwrite && is_buf;
	// Empty strobe means nothing to store
	assign lane0_wr  = buf_wr && pstrb[0];
	// Empty commits are dropped here
	assign commit_wr = pready && pwrite && is_commit && (frame_bytes != '0);

	// Highest strobed lane, strobes contiguous from lane 0
	always_comb begin
		if (pstrb[3]) begin
			last_lane = 2'd3;
		end else if (pstrb[2]) begin
			last_lane = 2'd2;
		end else if (pstrb[1]) begin
			last_lane = 2'd1;
		end else begin
			last_lane = 2'd0;
		end
	end

	// One byte per cycle, lane 0 first
	assign push_next = lane0_wr || (pend_cnt != '0);

	//////////////////////////////
	// Serializer and frame length

	always_ff @(posedge apb) begin
		if (rst) begin
			push.push   <= 1'b0;
			push.commit <= 1'b0;
			pend_cnt    <= '0;
			frame_bytes <= '0;
		end else begin
			push.push   <= push_next;
			push.commit <= commit_wr;
			if (lane0_wr) begin
				pend_cnt <= last_lane;
			end else if (pend_cnt != '0) begin
				pend_cnt <= pend_cnt - 1'b1;
			end
			// Count at schedule time so a commit sees every byte
			if (commit_wr) begin
				frame_bytes <= '0;
			end else if (push_next) begin
				frame_bytes <= frame_bytes + 1'b1;
			end
		end
	end

	// Payload path
	always_ff @(posedge apb) begin
		if (lane0_wr) begin
			push.data <= pwdata[7:0];
			pend_data <= pwdata[31:8];
		end else if (pend_cnt != '0) begin
			push.data <= pend_data[7:0];
			pend_data <= {8'h0, pend_data[23:8]};
		end
		if (commit_wr) begin
			push.commit_len <= frame_bytes;
		end
	end

	//////////////////////////////
	// Credit counters

	always_ff @(posedge apb) begin
		if (rst) begin
			byte_cred  <= byte_credit_t'(`ETH_TX_DATA_DEPTH);
			frame_cred <= frame_credit_t'(`ETH_TX_HDR_DEPTH);
		end else begin
			byte_cred  <= byte_cred - byte_credit_t'(push_next)
				+ byte_credit_t'(push.byte_credit);
			frame_cred <= frame_cred - frame_credit_t'(commit_wr)
				+ frame_credit_t'(push.frame_credit);
		end
	end

	// Every scheduled byte must own a slot in the store
	a_push_credit: assert property (@(posedge apb) disable iff (rst)
		push_next |-> (byte_cred != '0));

	// Store never hands back more than it was given
	a_credit_bound: assert property (@(posedge apb) disable iff (rst)
		(byte_cred <= `ETH_TX_DATA_DEPTH) && (frame_cred <= `ETH_TX_HDR_DEPTH));

endmodule

//--- rtl/tx_frame_store.sv
`timescale 1ns/1ps
`include "eth_tx_defines.svh"

module tx_frame_store (
	input logic      apb,
	input logic      rst,
	tx_push_if.store push,
	tx_pop_if.store  pop
);
	import eth_tx_frame_pkg::*;

	localparam int DATA_AW = $clog2(`ETH_TX_DATA_DEPTH);
	localparam int HDR_AW  = $clog2(`ETH_TX_HDR_DEPTH);

	// Byte FIFO
	logic [7:0]         byte_mem [`ETH_TX_DATA_DEPTH];
	logic [DATA_AW-1:0] byte_wr_ptr;
	logic [DATA_AW-1:0] byte_rd_ptr;
	logic [DATA_AW:0]   byte_cnt;

	// Length FIFO
	frame_len_t         len_mem [`ETH_TX_HDR_DEPTH];
	logic [HDR_AW-1:0]  len_wr_ptr;
	logic [HDR_AW-1:0]  len_rd_ptr;
	logic [HDR_AW:0]    len_cnt;

	//////////////////////////////
	// Storage

	always_ff @(posedge apb) begin
		if (push.push) begin
			byte_mem[byte_wr_ptr] <= push.data;
		end
		// Read data lands one cycle after the pop
		if (pop.byte_pop) begin
			pop.byte_data <= byte_mem[byte_rd_ptr];
		end
		if (push.commit) begin
			len_mem[len_wr_ptr] <= push.commit_len;
		end
	end

	// Head length is visible before the pop
	assign pop.frame_avail = (len_cnt != '0);
	assign pop.frame_len   = len_mem[len_rd_ptr];

	//////////////////////////////
	// Pointers, occupancy and credit return

	always_ff @(posedge apb) begin
		if (rst) begin
			byte_wr_ptr       <= '0;
			byte_rd_ptr       <= '0;
			byte_cnt          <= '0;
			len_wr_ptr        <= '0;
			len_rd_ptr        <= '0;
			len_cnt           <= '0;
			push.byte_credit  <= 1'b0;
			push.frame_credit <= 1'b0;
		end else begin
			// Power of two depths, pointers wrap by themselves
			if (push.push) begin
				byte_wr_ptr <= byte_wr_ptr + 1'b1;
			end
			if (pop.byte_pop) begin
				byte_rd_ptr <= byte_rd_ptr + 1'b1;
			end
			byte_cnt <= byte_cnt + (DATA_AW+1)'(push.push) - (DATA_AW+1)'(pop.byte_pop);

			if (push.commit) begin
				len_wr_ptr <= len_wr_ptr + 1'b1;
			end
			if (pop.frame_pop) begin
				len_rd_ptr <= len_rd_ptr + 1'b1;
			end
			len_cnt <= len_cnt + (HDR_AW+1)'(push.commit) - (HDR_AW+1)'(pop.frame_pop);

			// Each freed entry goes back to the writer
			push.byte_credit  <= pop.byte_pop;
			push.frame_credit <= pop.frame_pop;
		end
	end

	// Sender only pops what is there
	a_no_underflow: assert property (@(posedge apb) disable iff (rst)
		(pop.byte_pop |-> (byte_cnt != '0)) and (pop.frame_pop |-> (len_cnt != '0)));

	// Writer credits keep both memories from overflowing
	a_no_overflow: assert property (@(posedge apb) disable iff (rst)
		(push.push |-> (byte_cnt < `ETH_TX_DATA_DEPTH))
		and (push.commit |-> (len_cnt < `ETH_TX_HDR_DEPTH)));

endmodule

//--- rtl/tx_frame_sender.sv
`timescale 1ns/1ps

module tx_frame_sender (
	input  logic       apb,
	input  logic       rst,
	input  logic       tx_ready,
	output logic       tx_start,
	output logic       tx_valid,
	output logic [7:0] tx_data,
	tx_pop_if.sender   pop
);
	import eth_tx_frame_pkg::*;

	send_state_t state;
	frame_len_t  len_q;
	frame_len_t  sent;
	// First byte_pop of a frame, becomes tx_start a cycle later
	logic        start_pop;

	// Store output is already registered
	assign tx_data = pop.byte_data;

	always_ff @(posedge apb) begin
		if (rst) begin
			state         <= SEND_IDLE;
			pop.frame_pop <= 1'b0;
			pop.byte_pop  <= 1'b0;
			start_pop     <= 1'b0;
			sent          <= '0;
			tx_start      <= 1'b0;
			tx_valid      <= 1'b0;
		end else begin
			pop.frame_pop <= 1'b0;
			pop.byte_pop  <= 1'b0;
			start_pop     <= 1'b0;
			// Markers trail the pops to line up with byte_data
			tx_start      <= start_pop;
			tx_valid      <= pop.byte_pop;

			case (state)
				// tx_ready only matters between frames
				SEND_IDLE: begin
					if (pop.frame_avail && tx_ready) begin
						pop.frame_pop <= 1'b1;
						state         <= SEND_POP;
					end
				end
				SEND_POP: begin
					pop.byte_pop <= 1'b1;
					start_pop    <= 1'b1;
					sent         <= frame_len_t'(1);
					state        <= SEND_DATA;
				end
				SEND_DATA: begin
					if (sent >= len_q) begin
						state <= SEND_IDLE;
					end else begin
						pop.byte_pop <= 1'b1;
						sent         <= sent + 1'b1;
					end
				end
				default: begin
					state <= SEND_IDLE;
				end
			endcase
		end
	end

	// Header latched on the same edge the store drops it
	always_ff @(posedge apb) begin
		if (state == SEND_POP) begin
			len_q <= pop.frame_len;
		end
	end

	// Start marker sits on a valid byte and opens a burst after an idle cycle
	a_start_with_valid: assert property (@(posedge apb) disable iff (rst)
		tx_start |-> (tx_valid && !$past(tx_valid)));

endmodule

//--- rtl/eth_tx_buffer.sv
`timescale 1ns/1ps

module eth_tx_buffer (
	input  logic                      apb,
	input  logic                      rst,

	// APB completer
	input  eth_tx_reg_pkg::apb_addr_t paddr,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic [31:0]               pwdata,
	input  logic [3:0]                pstrb,
	output logic [31:0]               prdata,
	output logic                      pready,
	output logic                      pslverr,

	input  logic                      link_up,

	// MAC byte stream
	input  logic                      tx_ready,
	output logic                      tx_start,
	output logic                      tx_valid,
	output logic [7:0]                tx_data
);

	//////////////////////////////
	// Internal buses

	tx_push_if i_push ();
	tx_pop_if  i_pop ();

	//////////////////////////////
	// Blocks

	// Register front end and serializer
	apb_tx_regs i_regs (
		.apb     (apb),
		.rst     (rst),
		.paddr   (paddr),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.pwdata  (pwdata),
		.pstrb   (pstrb),
		.link_up (link_up),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.push    (i_push.writer)
	);

	// Byte and length FIFOs
	tx_frame_store i_store (
		.apb  (apb),
		.rst  (rst),
		.push (i_push.store),
		.pop  (i_pop.store)
	);

	// Frame pop FSM toward the MAC
	tx_frame_sender i_sender (
		.apb      (apb),
		.rst      (rst),
		.tx_ready (tx_ready),
		.tx_start (tx_start),
		.tx_valid (tx_valid),
		.tx_data  (tx_data),
		.pop      (i_pop.sender)
	);

endmodule

//--- verif/tb_eth_tx_buffer.sv
`timescale 1ns/1ps

module tb_eth_tx_buffer;
	import eth_tx_reg_pkg::*;

	// Each test is a few hundred cycles at most, stalls included
	localparam int TIMEOUT_CYCLES = 20000;

	logic        apb;
	logic        rst;
	apb_addr_t   paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] pwdata;
	logic [3:0]  pstrb;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        link_up;
	logic        tx_ready;
	logic        tx_start;
	logic        tx_valid;
	logic [7:0]  tx_data;

	integer      seed;
	int          cycles = 0;
	// Bytes written since the last commit
	int          pend_bytes;
	// Expected and received streams, start offsets per frame
	logic [7:0]  exp_q[$];
	logic [7:0]  rx_q[$];
	int          exp_start_q[$];
	int          rx_start_q[$];

	eth_tx_buffer i_dut (
		.apb      (apb),
		.rst      (rst),
		.paddr    (paddr),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.pwdata   (pwdata),
		.pstrb    (pstrb),
		.prdata   (prdata),
		.pready   (pready),
		.pslverr  (pslverr),
		.link_up  (link_up),
		.tx_ready (tx_ready),
		.tx_start (tx_start),
		.tx_valid (tx_valid),
		.tx_data  (tx_data)
	);

	//////////////////////////////
	// Clock, timeout and MAC side monitor

	initial begin
		apb = 1'b0;
		forever begin
			#10 apb = ~apb;
		end
	end

	always @(posedge apb) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the DUT stopped responding", cycles);
			$display("Done: errors found");
			$fatal(1, "Simulation timed out");
		end
	end

	// Registered outputs, stable at the falling edge
	always @(negedge apb) begin
		if (!rst) begin
			if (tx_start && !tx_valid) begin
				$display("tx_start went high without tx_valid");
				$display("Done: errors found");
				$fatal(1, "Start marker without data");
			end
			if (tx_valid) begin
				if (tx_start) begin
					rx_start_q.push_back(rx_q.size());
				end
				rx_q.push_back(tx_data);
			end
		end
	end

	//////////////////////////////
	// Helpers

	task automatic check_equal(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
			$display("Done: errors found");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	// One APB transfer, setup then access until pready
	task automatic apb_access(input logic wr, input apb_addr_t addr, input logic [31:0] data,
		input logic [3:0] strb, output logic [31:0] rdata, output logic err);
		@(negedge apb);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = data;
		pstrb   = strb;
		@(negedge apb);
		penable = 1'b1;
		// Completer state only changes after the edge
		@(posedge apb);
		while (!pready) begin
			@(posedge apb);
		end
		rdata = prdata;
		err   = pslverr;
		@(negedge apb);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic write_word(input logic [3:0] strb);
		logic [31:0] word;
		logic [31:0] rdata;
		logic        err;
		int          lane;
		word = $random(seed);
		apb_access(1'b1, REG_TX_BUF, word, strb, rdata, err);
		check_equal("pslverr", 32'(err), 0);
		// Lane 0 leaves first
		for (lane = 0; lane < 4; lane++) begin
			if (strb[lane]) begin
				exp_q.push_back(word[8*lane +: 8]);
				pend_bytes++;
			end
		end
	endtask

	// Full words, then one partial word for the tail
	task automatic write_frame(input int n);
		int left;
		left = n;
		while (left >= 4) begin
			write_word(4'hf);
			left -= 4;
		end
		if (left > 0) begin
			write_word(4'((1 << left) - 1));
		end
	endtask

	task automatic commit_frame();
		logic [31:0] rdata;
		logic        err;
		apb_access(1'b1, REG_COMMIT, 32'h1, 4'hf, rdata, err);
		check_equal("pslverr", 32'(err), 0);
		// Nothing written means no frame
		if (pend_bytes > 0) begin
			exp_start_q.push_back(exp_q.size() - pend_bytes);
			pend_bytes = 0;
		end
	endtask

	task automatic compare_frames();
		int i;
		while (rx_q.size() < exp_q.size()) begin
			@(negedge apb);
		end
		// Room for stray bytes or frames to show up
		repeat (20) @(negedge apb);
		check_equal("tx_valid byte count", rx_q.size(), exp_q.size());
		check_equal("tx_start count", rx_start_q.size(), exp_start_q.size());
		for (i = 0; i < exp_q.size(); i++) begin
			check_equal("tx_data", 32'(rx_q[i]), 32'(exp_q[i]));
		end
		for (i = 0; i < exp_start_q.size(); i++) begin
			check_equal("tx_start position", rx_start_q[i], exp_start_q[i]);
		end
		exp_q.delete();
		rx_q.delete();
		exp_start_q.delete();
		rx_start_q.delete();
	endtask

	//////////////////////////////
	// Tests

	task automatic register_access();
		logic [31:0] rdata;
		logic        err;
		link_up = 1'b0;
		apb_access(1'b0, REG_STAT, 32'h0, 4'h0, rdata, err);
		check_equal("prdata", rdata, 32'h0);
		check_equal("pslverr", 32'(err), 0);
		link_up = 1'b1;
		apb_access(1'b0, REG_STAT, 32'h0, 4'h0, rdata, err);
		check_equal("prdata", rdata, 32'h1);
		check_equal("pslverr", 32'(err), 0);
		// Status is read only, the window is write only
		apb_access(1'b1, REG_STAT, 32'h0, 4'hf, rdata, err);
		check_equal("pslverr", 32'(err), 1);
		apb_access(1'b0, REG_TX_BUF, 32'h0, 4'h0, rdata, err);
		check_equal("pslverr", 32'(err), 1);
	endtask

	task automatic full_word_frame();
		write_frame(20);
		commit_frame();
		compare_frames();
	endtask

	task automatic partial_strobe_frame();
		write_word(4'b0001);
		write_word(4'b0011);
		write_word(4'b0111);
		commit_frame();
		commit_frame();
		compare_frames();
	endtask

	task automatic ready_backpressure();
		tx_ready = 1'b0;
		write_frame(12);
		commit_frame();
		write_frame(2);
		commit_frame();
		write_frame(7);
		commit_frame();
		repeat (40) @(negedge apb);
		check_equal("tx_valid byte count", rx_q.size(), 0);
		tx_ready = 1'b1;
		compare_frames();
	endtask

	task automatic credit_backpressure();
		logic commit_done;
		int   starts_at_done;
		commit_done    = 1'b0;
		starts_at_done = 0;
		tx_ready       = 1'b0;
		write_frame(5);
		commit_frame();
		write_frame(9);
		commit_frame();
		write_frame(4);
		commit_frame();
		write_frame(6);
		commit_frame();
		// Fifth payload fits, its header slot does not
		write_frame(8);
		fork
			begin
				commit_frame();
				commit_done    = 1'b1;
				starts_at_done = rx_start_q.size();
			end
			begin
				repeat (30) @(negedge apb);
				check_equal("commit done", 32'(commit_done), 0);
				check_equal("pready", 32'(pready), 0);
				tx_ready = 1'b1;
			end
		join
		check_equal("frame started before commit", 32'(starts_at_done > 0), 1);
		compare_frames();
	endtask

	initial begin
		seed       = 29396;
		pend_bytes = 0;
		rst        = 1'b1;
		paddr      = REG_STAT;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		pwdata     = 32'h0;
		pstrb      = 4'h0;
		link_up    = 1'b0;
		tx_ready   = 1'b1;
		repeat (5) @(negedge apb);
		rst = 1'b0;

		register_access();
		full_word_frame();
		partial_strobe_frame();
		ready_backpressure();
		credit_backpressure();

		$display("Done: no errors");
		$finish;
	end

endmodule

//--- eth_tx_buffer.f
+incdir+include
rtl/eth_tx_reg_pkg.sv
rtl/eth_tx_frame_pkg.sv
rtl/eth_tx_ifs.sv
rtl/apb_tx_regs.sv
rtl/tx_frame_store.sv
rtl/tx_frame_sender.sv
rtl/eth_tx_buffer.sv
verif/tb_eth_tx_buffer.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_eth_tx_buffer
FILELIST = eth_tx_buffer.f
PASS     = Done: no errors

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASS)"

clean:
	rm -rf obj_dir
